// ==== scanner.f ====
verilog/scanner_pkg.sv
verilog/scan_tick_gen.sv
verilog/sync_stage.sv
verilog/scan_sequencer.sv
verilog/scanner_top.sv
verification/scanner_chk.sv
verification/scanner_monitor.sv
verification/scanner_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the scanner testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module scanner_tb -Mdir obj_dir -o Vscanner_tb -f scanner.f

./obj_dir/Vscanner_tb +verilator+error+limit+1000 | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log
then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

// ==== verification/scanner_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module scanner_tb
    import scanner_pkg::*;
();

    localparam int TICK_DIV   = 8;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_MOVE   = 40;             // ticks, slowest servo move
    localparam int IDLE_TICKS = 20;             // start held low between scans
    localparam int RUN_TICKS  = 2 * NUM_STEPS * (MAX_MOVE + 2) + 3 * IDLE_TICKS + 100;

    logic        I_sys_clk;
    logic        I_rst_button;
    logic        start;
    logic        end_run;
    logic [5:0]  done_drv;                      // dir1 in the msb, as servo_done_t
    logic [5:0]  cmd_obs;
    logic        motor_clk;
    face_t       face;
    logic        scan_done;
    logic [31:0] rng_state;
    int          mon_errors;
    int          mon_tests;
    int          mon_failed;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // move time of one servo in ticks, 1..MAX_MOVE
    function automatic int draw_move_ticks();
        rng_state = xorshift32(rng_state);
        return 1 + int'(rng_state % 32'd40);
    endfunction

    task automatic run_scan();
        #1;
        start = 1'b1;
        while (scan_done !== 1'b0)
        begin
            @(posedge I_sys_clk);
            #1;
        end
        start = 1'b0;                           // scan runs on without start
        while (scan_done !== 1'b1)
        begin
            @(posedge I_sys_clk);
            #1;
        end
    endtask

    initial
    begin
        I_sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) I_sys_clk = ~I_sys_clk;
    end

    // ------------------------------
    // servo models
    // ------------------------------
    initial
    begin : servo_models
        logic [5:0] seen_cmd;
        logic [5:0] next_done;
        int         remain [6];
        rng_state = 32'h4cc7_ec41;
        done_drv  = 6'b111_111;                 // all servos at rest
        seen_cmd  = 6'b000_000;
        for (int i = 0; i < 6; i++)
            remain[i] = 0;
        forever
        begin
            @(posedge I_sys_clk);
            next_done = done_drv;
            for (int i = 0; i < 6; i++)
            begin
                if (cmd_obs[i] != seen_cmd[i])
                begin
                    seen_cmd[i]  = cmd_obs[i];
                    next_done[i] = 1'b0;        // servo starts moving
                    remain[i]    = draw_move_ticks() * TICK_DIV;
                end
                else if (remain[i] > 0)
                begin
                    remain[i] = remain[i] - 1;
                    if (remain[i] == 0)
                        next_done[i] = 1'b1;
                end
            end
            #1;
            done_drv = next_done;
        end
    end

    // ------------------------------
    // stimulus and result
    // ------------------------------
    initial
    begin
        I_rst_button = 1'b1;
        start        = 1'b0;
        end_run      = 1'b0;
        repeat (3) @(posedge I_sys_clk);
        #1 I_rst_button = 1'b0;
        repeat (IDLE_TICKS * TICK_DIV) @(posedge I_sys_clk);
        run_scan();
        repeat (IDLE_TICKS * TICK_DIV) @(posedge I_sys_clk);
        run_scan();
        repeat (IDLE_TICKS * TICK_DIV) @(posedge I_sys_clk);
        #1 end_run = 1'b1;
        repeat (2) @(posedge I_sys_clk);
        #1;
        $display("summary: %0d tests, %0d with errors, %0d check errors, %0d assertion failures",
                 mon_tests, mon_failed, mon_errors, DUT.u_chk.fail_cnt);
        if (mon_errors == 0 && mon_failed == 0 && mon_tests == 5 && DUT.u_chk.fail_cnt == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial
    begin
        #(RUN_TICKS * TICK_DIV * CLK_PERIOD);
        $display("timeout: the two scans did not finish within %0d ticks", RUN_TICKS);
        $display("SIMULATION FAILED");
        $finish;
    end

    scanner_top #(.TICK_DIV(TICK_DIV)) DUT (
        .I_sys_clk            (I_sys_clk),
        .I_rst_button         (I_rst_button),
        .i_start_button       (start),
        .i_dir1_done          (done_drv[5]),
        .i_dir2_done          (done_drv[4]),
        .i_dir3_done          (done_drv[3]),
        .i_grip1_done         (done_drv[2]),
        .i_grip2_done         (done_drv[1]),
        .i_grip3_done         (done_drv[0]),
        .o_servo1_directional (cmd_obs[5]),
        .o_servo2_directional (cmd_obs[4]),
        .o_servo3_directional (cmd_obs[3]),
        .o_servo1_gripping    (cmd_obs[2]),
        .o_servo2_gripping    (cmd_obs[1]),
        .o_servo3_gripping    (cmd_obs[0]),
        .o_motor_clk          (motor_clk),
        .o_face               (face),
        .o_scan_done          (scan_done)
    );

    scanner_monitor #(.TICK_DIV(TICK_DIV)) MON (
        .I_sys_clk    (I_sys_clk),
        .I_rst_button (I_rst_button),
        .i_cmd        (cmd_obs),
        .i_done       (done_drv),
        .i_face       (face),
        .i_scan_done  (scan_done),
        .i_motor_clk  (motor_clk),
        .i_end        (end_run),
        .o_errors     (mon_errors),
        .o_tests      (mon_tests),
        .o_failed     (mon_failed)
    );

endmodule

`default_nettype wire

// ==== verification/scanner_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module scanner_monitor
    import scanner_pkg::*;
#(
    parameter int TICK_DIV = 8
) (
    input  logic        I_sys_clk,
    input  logic        I_rst_button,
    input  servo_cmd_t  i_cmd,
    input  servo_done_t i_done,
    input  face_t       i_face,
    input  logic        i_scan_done,
    input  logic        i_motor_clk,
    input  logic        i_end,
    output int          o_errors,
    output int          o_tests,
    output int          o_failed
);

    servo_cmd_t last_cmd;
    face_t      last_face;
    logic       last_mclk;
    step_t      exp;
    logic [5:0] prev_diff;                      // servos moved at the last change
    int         high_cnt [6];
    int         step_k;
    int         scans;
    int         scan_errs;
    int         scan_total;
    int         idle_errs;
    int         hs_errs;
    int         mclk_errs;
    int         mclk_gap;
    int         mclk_seen;
    logic       end_seen;

    // word and face of step k, from the vertical and horizontal blocks
    function automatic step_t expected_cmd(input int k);
        int    blk;
        int    pos;
        step_t s;
        blk    = (k - 1) / 4;
        pos    = (k - 1) % 4;
        s.cmd  = 6'b000_000;                    // load and final release
        s.face = 3'd1;
        if (k == NUM_STEPS - 1)
            s.face = 3'd6;
        else if (k > 0)
        begin
            s.face = face_t'(blk + 2);
            if (blk < 3)                        // faces 2..4
                case (pos)
                    0:       s.cmd = 6'b110_000;
                    1:       s.cmd = 6'b000_001;
                    2:       s.cmd = 6'b000_111;
                    default: s.cmd = 6'b000_110;
                endcase
            else                                // faces 5 and 6
                case (pos)
                    0:       s.cmd = 6'b001_000;
                    1:       s.cmd = 6'b000_110;
                    2:       s.cmd = 6'b000_111;
                    default: s.cmd = 6'b000_001;
                endcase
        end
        return s;
    endfunction

    task automatic report_test(input string name, input int errs);
        o_tests = o_tests + 1;
        if (errs != 0)
            o_failed = o_failed + 1;
        $display("test %s : %s, %0d errors", name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    always @(posedge I_sys_clk)
    begin
        if (I_rst_button)
        begin
            step_k     = 0;
            scans      = 0;
            scan_errs  = 0;
            scan_total = 0;
            idle_errs  = 0;
            hs_errs    = 0;
            mclk_errs  = 0;
            mclk_gap   = 0;
            mclk_seen  = 0;
            o_tests    = 0;
            o_failed   = 0;
            prev_diff  = '0;
            end_seen   = 1'b0;
            for (int i = 0; i < 6; i++)
                high_cnt[i] = 0;
        end
        // ------------------------------
        // idle and done flag
        // ------------------------------
        if (i_face == FACE_NONE && (i_cmd != '0 || !i_scan_done))
        begin
            idle_errs++;
            $display("error: idle servo outputs 0x%h o_scan_done 0x%h, expected 0x00 and 0x1",
                     i_cmd, i_scan_done);
        end
        if (i_face != FACE_NONE && i_scan_done)
        begin
            scan_errs++;
            $display("error: o_scan_done in face 0x%h expected 0x0, got 0x1", i_face);
        end
        if (!I_rst_button)
        begin
            // ------------------------------
            // step words
            // ------------------------------
            if (i_cmd != last_cmd || i_face != last_face)
            begin
                if (i_face == FACE_NONE)
                begin
                    if (step_k != NUM_STEPS)
                    begin
                        scan_errs++;
                        $display("scan ended after %0d of %0d steps", step_k, NUM_STEPS);
                    end
                    scans++;
                    scan_total += scan_errs;
                    report_test($sformatf("scan_%0d", scans), scan_errs);
                    scan_errs = 0;
                end
                else
                begin
                    if (last_face == FACE_NONE)
                        step_k = 0;             // new scan
                    exp = expected_cmd(step_k);
                    if (step_k >= NUM_STEPS)
                    begin
                        scan_errs++;
                        $display("extra command word after the last step");
                    end
                    else if (i_cmd != exp.cmd || i_face != exp.face)
                    begin
                        scan_errs++;
                        $display("error: servo outputs/o_face step %0d expected %h/%h, got %h/%h",
                                 step_k, exp.cmd, exp.face, i_cmd, i_face);
                    end
                    step_k++;
                end
            end
            // ------------------------------
            // handshake
            // ------------------------------
            // the end of a scan also waits on the last step's servos
            if (i_cmd != last_cmd || (i_face == FACE_NONE && last_face != FACE_NONE))
            begin
                for (int i = 0; i < 6; i++)
                    if (prev_diff[i] && high_cnt[i] < 3)
                    begin
                        hs_errs++;
                        $display("servo bit %0d moved on after its done was high only %0d cycles",
                                 i, high_cnt[i]);
                    end
                prev_diff = i_cmd ^ last_cmd;
            end
            for (int i = 0; i < 6; i++)
                high_cnt[i] = i_done[i] ? high_cnt[i] + 1 : 0;
            if (i_motor_clk != last_mclk)
            begin
                if (mclk_seen > 0 && mclk_gap != TICK_DIV)
                begin
                    mclk_errs++;
                    $display("error: o_motor_clk half period expected 0x%h, got 0x%h",
                             TICK_DIV, mclk_gap);
                end
                mclk_seen++;
                mclk_gap = 1;
            end
            else
                mclk_gap++;
            if (i_end && !end_seen)
            begin
                end_seen = 1'b1;
                if (scans != 2)
                begin
                    idle_errs++;
                    $display("expected two completed scans, saw %0d", scans);
                end
                if (mclk_seen < 2)
                begin
                    mclk_errs++;
                    $display("motor clock never toggled");
                end
                report_test("idle", idle_errs);
                report_test("handshake", hs_errs);
                report_test("motor_clock", mclk_errs);
            end
        end
        last_cmd  = i_cmd;
        last_face = i_face;
        last_mclk = i_motor_clk;
        o_errors  = scan_total + scan_errs + idle_errs + hs_errs + mclk_errs;
    end

endmodule

`default_nettype wire

// ==== verification/scanner_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module scanner_chk
    import scanner_pkg::*;
(
    input logic       I_sys_clk,
    input logic       I_rst_button,
    input logic       i_tick,
    input servo_cmd_t i_cmd,
    input face_t      i_face,
    input logic       i_scan_done
);

    int fail_cnt = 0;                           // failed assertions so far

    // ------------------------------
    // outputs move only after a tick
    // ------------------------------
    a_cmd_on_tick : assert property (@(posedge I_sys_clk) disable iff (I_rst_button)
        !$stable(i_cmd) |-> $past(i_tick))
    else
    begin
        $error("servo command moved with no tick in the cycle before");
        fail_cnt++;
    end

    a_face_on_tick : assert property (@(posedge I_sys_clk) disable iff (I_rst_button)
        !$stable(i_face) |-> $past(i_tick))
    else
    begin
        $error("o_face moved with no tick in the cycle before");
        fail_cnt++;
    end

    // done flag and idle face go together
    a_done_is_idle : assert property (@(posedge I_sys_clk) disable iff (I_rst_button)
        i_scan_done == (i_face == FACE_NONE))
    else
    begin
        $error("o_scan_done disagrees with o_face");
        fail_cnt++;
    end

endmodule

bind scanner_top scanner_chk u_chk (
    .I_sys_clk    (I_sys_clk),
    .I_rst_button (I_rst_button),
    .i_tick       (tick),
    .i_cmd        (cmd),
    .i_face       (o_face),
    .i_scan_done  (o_scan_done)
);

`default_nettype wire

// ==== verilog/scanner_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module scanner_top
    import scanner_pkg::*;
#(
    parameter int TICK_DIV = 1_250_000          // 50 Hz motor clock at 125 MHz
) (
    input  logic  I_sys_clk,
    input  logic  I_rst_button,
    input  logic  i_start_button,
    input  logic  i_dir1_done,
    input  logic  i_dir2_done,
    input  logic  i_dir3_done,
    input  logic  i_grip1_done,
    input  logic  i_grip2_done,
    input  logic  i_grip3_done,
    output logic  o_servo1_directional,
    output logic  o_servo2_directional,
    output logic  o_servo3_directional,
    output logic  o_servo1_gripping,
    output logic  o_servo2_gripping,
    output logic  o_servo3_gripping,
    output logic  o_motor_clk,
    output face_t o_face,
    output logic  o_scan_done
);

    logic        tick;
    logic        start_sync;
    servo_done_t done_raw;
    servo_done_t done_sync;
    servo_cmd_t  cmd;

    // ------------------------------
    // input side
    // ------------------------------
    assign done_raw.dir1  = i_dir1_done;
    assign done_raw.dir2  = i_dir2_done;
    assign done_raw.dir3  = i_dir3_done;
    assign done_raw.grip1 = i_grip1_done;
    assign done_raw.grip2 = i_grip2_done;
    assign done_raw.grip3 = i_grip3_done;

    sync_stage #(.T(logic)) u_start_sync (
        .I_sys_clk    (I_sys_clk),
        .I_rst_button (I_rst_button),
        .i_async      (i_start_button),
        .o_sync       (start_sync)
    );

    sync_stage #(.T(servo_done_t)) u_done_sync (
        .I_sys_clk    (I_sys_clk),
        .I_rst_button (I_rst_button),
        .i_async      (done_raw),
        .o_sync       (done_sync)
    );

    // ------------------------------
    // timing and sequencing
    // ------------------------------
    scan_tick_gen #(.TICK_DIV(TICK_DIV)) u_tick_gen (
        .I_sys_clk    (I_sys_clk),
        .I_rst_button (I_rst_button),
        .o_tick       (tick),
        .o_motor_clk  (o_motor_clk)
    );

    scan_sequencer u_sequencer (
        .I_sys_clk    (I_sys_clk),
        .I_rst_button (I_rst_button),
        .i_tick       (tick),
        .i_start      (start_sync),
        .i_done       (done_sync),
        .o_cmd        (cmd),
        .o_face       (o_face),
        .o_scan_done  (o_scan_done)
    );

    // servo pins straight from the sequencer register
    assign o_servo1_directional = cmd.dir1;
    assign o_servo2_directional = cmd.dir2;
    assign o_servo3_directional = cmd.dir3;
    assign o_servo1_gripping    = cmd.grip1;
    assign o_servo2_gripping    = cmd.grip2;
    assign o_servo3_gripping    = cmd.grip3;

endmodule

`default_nettype wire

// ==== verilog/scan_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_sequencer
    import scanner_pkg::*;
(
    input  logic        I_sys_clk,
    input  logic        I_rst_button,
    input  logic        i_tick,
    input  logic        i_start,
    input  servo_done_t i_done,
    output servo_cmd_t  o_cmd,
    output face_t       o_face,
    output logic        o_scan_done
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } seq_state_t;

    localparam step_idx_t LAST_STEP = step_idx_t'(NUM_STEPS - 1);

    // ------------------------------
    // state
    // ------------------------------
    seq_state_t state_q;
    seq_state_t state_d;
    step_idx_t  step_q;
    step_idx_t  step_d;
    servo_cmd_t cmd_q;                          // word on the servo pins
    servo_cmd_t cmd_d;
    servo_cmd_t prev_q;                         // word before the current step
    servo_cmd_t prev_d;
    face_t      face_q;
    face_t      face_d;
    logic       scan_done_q;
    logic       scan_done_d;

    servo_cmd_t changed;
    servo_cmd_t waiting;
    logic       step_clear;
    step_idx_t  step_nxt;
    step_t      next_entry;

    // ------------------------------
    // wait set
    // ------------------------------
    // a servo is waited on only if its level moved at this step
    assign changed = cmd_q ^ prev_q;

    // done fields sit in the same bit positions as the command fields
    assign waiting = changed & ~i_done;

    assign step_clear = (waiting == '0);        // empty set clears at once
    assign step_nxt   = step_q + step_idx_t'(1);

    // ------------------------------
    // next state
    // ------------------------------
    always_comb
    begin
        state_d     = state_q;
        step_d      = step_q;
        cmd_d       = cmd_q;
        prev_d      = prev_q;
        face_d      = face_q;
        scan_done_d = scan_done_q;
        next_entry  = SCAN_PROGRAM[0];

        case (state_q)
            ST_IDLE:
            begin
                if (i_start)
                begin
                    next_entry  = SCAN_PROGRAM[0];
                    state_d     = ST_RUN;
                    step_d      = '0;
                    prev_d      = cmd_q;            // step 0 compares to idle word
                    cmd_d       = next_entry.cmd;
                    face_d      = next_entry.face;
                    scan_done_d = 1'b0;
                end
            end

            ST_RUN:
            begin
                if (step_clear)
                begin
                    prev_d = cmd_q;
                    if (step_q == LAST_STEP)
                    begin
                        state_d     = ST_IDLE;
                        face_d      = FACE_NONE;
                        scan_done_d = 1'b1;     // cmd stays at the release word
                    end
                    else
                    begin
                        next_entry = SCAN_PROGRAM[step_nxt];
                        step_d     = step_nxt;
                        cmd_d      = next_entry.cmd;
                        face_d     = next_entry.face;
                    end
                end
            end

            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // registers, moved on ticks only
    // ------------------------------
    always_ff @(posedge I_sys_clk or posedge I_rst_button)
    begin
        if (I_rst_button)
        begin
            state_q     <= ST_IDLE;
            step_q      <= '0;
            cmd_q       <= CMD_OFF;
            prev_q      <= CMD_OFF;
            face_q      <= FACE_NONE;
            scan_done_q <= 1'b1;
        end
        else if (i_tick)
        begin
            state_q     <= state_d;
            step_q      <= step_d;
            cmd_q       <= cmd_d;
            prev_q      <= prev_d;
            face_q      <= face_d;
            scan_done_q <= scan_done_d;
        end
    end

    assign o_cmd       = cmd_q;
    assign o_face      = face_q;
    assign o_scan_done = scan_done_q;

endmodule

`default_nettype wire

// ==== verilog/sync_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_stage
    import scanner_pkg::*;
#(
    parameter type T = logic
) (
    input  logic I_sys_clk,
    input  logic I_rst_button,
    input  T     i_async,
    output T     o_sync
);

    T sync_q [SYNC_STAGES];                     // stage 0 may go metastable

    always_ff @(posedge I_sys_clk or posedge I_rst_button)
    begin
        if (I_rst_button)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= '0;
            end
        end
        else
        begin
            sync_q[0] <= i_async;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign o_sync = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== verilog/scan_tick_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_tick_gen #(
    parameter int TICK_DIV = 1_250_000
) (
    input  logic I_sys_clk,
    input  logic I_rst_button,
    output logic o_tick,
    output logic o_motor_clk
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             motor_clk_q;
    logic             wrap;

    assign wrap = (cnt_q == CNT_LAST);          // one cycle in TICK_DIV

    // ------------------------------
    // divider
    // ------------------------------
    always_ff @(posedge I_sys_clk or posedge I_rst_button)
    begin
        if (I_rst_button)
        begin
            cnt_q       <= '0;
            motor_clk_q <= 1'b0;
        end
        else if (wrap)
        begin
            cnt_q       <= '0;
            motor_clk_q <= ~motor_clk_q;        // half period per tick
        end
        else
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign o_tick      = wrap;
    assign o_motor_clk = motor_clk_q;

endmodule

`default_nettype wire

// ==== verilog/scanner_pkg.sv ====
`default_nettype none

package scanner_pkg;

    // ------------------------------
    // servo bundles
    // ------------------------------

    // one command level per servo, dir1 in the msb
    typedef struct packed {
        logic dir1;
        logic dir2;
        logic dir3;
        logic grip1;
        logic grip2;
        logic grip3;
    } servo_cmd_t;

    // same field order as servo_cmd_t so the two line up bit for bit
    typedef struct packed {
        logic dir1;
        logic dir2;
        logic dir3;
        logic grip1;
        logic grip2;
        logic grip3;
    } servo_done_t;

    typedef logic [2:0] face_t;                 // 1..6 while scanning

    typedef struct packed {
        servo_cmd_t cmd;
        face_t      face;
    } step_t;

    // ------------------------------
    // sizes and constants
    // ------------------------------
    localparam int NUM_STEPS   = 22;
    localparam int SYNC_STAGES = 2;             // flops per synchronizer

    typedef logic [4:0] step_idx_t;

    localparam face_t FACE_NONE = 3'd0;         // idle, no face on show

    // command words, bits are dir1 dir2 dir3 grip1 grip2 grip3
    localparam servo_cmd_t CMD_OFF   = 6'b000_000;
    localparam servo_cmd_t CMD_DIR12 = 6'b110_000;  // both vertical arms turn
    localparam servo_cmd_t CMD_DIR3  = 6'b001_000;  // horizontal arm turns
    localparam servo_cmd_t CMD_G3    = 6'b000_001;
    localparam servo_cmd_t CMD_G12   = 6'b000_110;
    localparam servo_cmd_t CMD_G123  = 6'b000_111;

    // ------------------------------
    // step program
    // ------------------------------
    // faces 2..4 are vertical quarter turns, faces 5 and 6 horizontal turns
    localparam step_t SCAN_PROGRAM [NUM_STEPS] = '{
        '{CMD_OFF,   3'd1},     // step 0, first face as loaded
        '{CMD_DIR12, 3'd2},     // vertical block, face 2
        '{CMD_G3,    3'd2},
        '{CMD_G123,  3'd2},
        '{CMD_G12,   3'd2},
        '{CMD_DIR12, 3'd3},     // vertical block, face 3
        '{CMD_G3,    3'd3},
        '{CMD_G123,  3'd3},
        '{CMD_G12,   3'd3},
        '{CMD_DIR12, 3'd4},     // vertical block, face 4
        '{CMD_G3,    3'd4},
        '{CMD_G123,  3'd4},
        '{CMD_G12,   3'd4},
        '{CMD_DIR3,  3'd5},     // horizontal block, face 5
        '{CMD_G12,   3'd5},
        '{CMD_G123,  3'd5},
        '{CMD_G3,    3'd5},
        '{CMD_DIR3,  3'd6},     // horizontal block, face 6
        '{CMD_G12,   3'd6},
        '{CMD_G123,  3'd6},
        '{CMD_G3,    3'd6},
        '{CMD_OFF,   3'd6}      // final release
    };

endpackage

`default_nettype wire
